// File: filelist.f
+incdir+logic
logic/prf_data_pkg.sv
logic/prf_free_pkg.sv
logic/prf_alloc_picker.sv
logic/prf_free_list.sv
logic/prf_entry_array.sv
logic/prf_operand_read.sv
logic/prf_top.sv
tests/prf_tb.sv

// File: logic/prf_alloc_picker.sv
////////////////////
// chooses up to two free entries per cycle for the renamer
// purely combinational, the grant mask goes on to the free list and entry array
////////////////////

`timescale 1ns/100ps

`include "prf_params.svh"

module prf_alloc_picker (
	input  logic                   alloc_req1,	// renamer wants a first register
	input  logic                   alloc_req2,	// renamer wants a (second) register
	input  prf_free_pkg::prf_vec_t available,	// 1 marks an entry that can be handed out
	output prf_free_pkg::prf_vec_t grant_mask,	// entries taken this cycle
	output logic                   alloc_valid1,
	output logic                   alloc_valid2,
	output prf_data_pkg::prf_tag_t alloc_idx1,
	output prf_data_pkg::prf_tag_t alloc_idx2
);

	import prf_data_pkg::*;
	import prf_free_pkg::*;

	// lowest set bit of a mask, or 0 when the mask is empty
	function automatic prf_tag_t lowest_index(input prf_vec_t vec);
		prf_tag_t idx;
		idx = '0;
		for (int i = `PRF_SIZE-1; i >= 0; i--)	// scan downward so the lowest hit lands last
		begin
			if (vec[i])
				idx = prf_tag_t'(i);
		end
		return idx;
	endfunction

	prf_vec_t avail_rest;	// availability with the first pick taken out
	prf_tag_t first_idx;
	prf_tag_t second_idx;
	logic     first_ok;	// at least one entry free
	logic     second_ok;	// at least two entries free

	////////////////////
	// two-level scan
	////////////////////

	assign first_idx  = lowest_index(available);
	assign first_ok   = |available;
	assign avail_rest = available & ~(prf_vec_t'(1) << first_idx);
	assign second_idx = lowest_index(avail_rest);
	assign second_ok  = |avail_rest;

	// req1 always takes the lowest entry, req2 takes the next one when req1 is also up
	always_comb
	begin
		alloc_valid1 = alloc_req1 & first_ok;
		alloc_idx1   = alloc_valid1 ? first_idx : '0;
		alloc_valid2 = alloc_req2 & (alloc_req1 ? second_ok : first_ok);
		alloc_idx2   = '0;
		if (alloc_valid2)
			alloc_idx2 = alloc_req1 ? second_idx : first_idx;

		// only granted entries show up in the mask
		grant_mask = '0;
		if (alloc_valid1)
			grant_mask[alloc_idx1] = 1'b1;
		if (alloc_valid2)
			grant_mask[alloc_idx2] = 1'b1;
	end

endmodule

// File: logic/prf_data_pkg.sv
////////////////////
// register tag and register value types shared by the PRF blocks
// import wherever a tag or a stored value is carried
////////////////////

package prf_data_pkg;

	`include "prf_params.svh"

	////////////////////
	// tags
	////////////////////

	localparam int PRF_TAG_W = $clog2(`PRF_SIZE);	// bits needed to name one entry

	typedef logic [PRF_TAG_W-1:0] prf_tag_t;	// physical register index

	// the zero register as a tag, for compares against incoming indices
	localparam prf_tag_t PRF_ZERO_TAG = prf_tag_t'(`PRF_ZERO_IDX);

	////////////////////
	// values
	////////////////////

	typedef logic [`PRF_DATA_W-1:0] prf_value_t;	// one register's contents

endpackage

// File: logic/prf_entry_array.sv
////////////////////
// stored value and ready bit of every physical register
// written by the two CDB ports, ready cleared when an entry is allocated
////////////////////

`timescale 1ns/100ps

`include "prf_params.svh"

module prf_entry_array (
	input  logic                     clock,
	input  logic                     rst_n,
	input  prf_free_pkg::prf_vec_t   grant_mask,	// freshly allocated entries
	input  logic                     cdb1_valid,
	input  prf_data_pkg::prf_tag_t   cdb1_tag,
	input  prf_data_pkg::prf_value_t cdb1_value,
	input  logic                     cdb2_valid,
	input  prf_data_pkg::prf_tag_t   cdb2_tag,
	input  prf_data_pkg::prf_value_t cdb2_value,
	output prf_free_pkg::prf_vec_t   ready,	// 1 once a result has been written
	output prf_data_pkg::prf_value_t values [`PRF_SIZE]
);

	import prf_data_pkg::*;
	import prf_free_pkg::*;

	prf_vec_t wr1;	// per-entry hits from CDB 1
	prf_vec_t wr2;	// per-entry hits from CDB 2

	////////////////////
	// write decode
	////////////////////

	always_comb
	begin
		wr1 = '0;
		wr2 = '0;
		if (cdb1_valid && (cdb1_tag != PRF_ZERO_TAG))
			wr1[cdb1_tag] = 1'b1;
		if (cdb2_valid && (cdb2_tag != PRF_ZERO_TAG))	// zero register writes are dropped
			wr2[cdb2_tag] = 1'b1;
	end

	// CDB results land in the value store at the edge
	always_ff @(posedge clock)
	begin
		for (int i = 0; i < `PRF_SIZE; i++)
		begin
			if (wr2[i])
				values[i] <= cdb2_value;	// CDB 2 wins on a shared tag
			else if (wr1[i])
				values[i] <= cdb1_value;
		end
	end

	////////////////////
	// ready bits
	////////////////////

	always_ff @(posedge clock)
	begin
		if (!rst_n)
			ready <= '0;
		else
		begin
			// a new allocation means the old value is stale until its producer writes back
			ready <= (ready | wr1 | wr2) & ~grant_mask;
		end
	end

endmodule

// File: logic/prf_free_list.sv
////////////////////
// availability bit per physical register
// takes grants from the picker and frees from retirement or a mispredict
////////////////////

`timescale 1ns/100ps

`include "prf_params.svh"

module prf_free_list (
	input  logic                   clock,
	input  logic                   rst_n,
	input  prf_free_pkg::prf_vec_t grant_mask,	// entries allocated this cycle
	input  logic                   free1_valid,	// first retire free
	input  logic                   free2_valid,	// second retire free
	input  prf_data_pkg::prf_tag_t free1_idx,
	input  prf_data_pkg::prf_tag_t free2_idx,
	input  logic                   mispredict_free_valid,	// branch recovery in progress
	input  prf_free_pkg::prf_vec_t mispredict_free_list,	// entries the recovery hands back
	output prf_free_pkg::prf_vec_t available,	// 1 marks a free entry
	output logic                   prf_is_full	// nothing left to allocate
);

	import prf_free_pkg::*;

	prf_vec_t free_mask;	// entries returned to the pool this cycle
	prf_vec_t avail_next;

	////////////////////
	// free mask
	////////////////////

	always_comb
	begin
		free_mask = '0;
		if (mispredict_free_valid)
		begin
			// the recovery list already covers anything retirement would free,
			// so the retire ports are ignored for this cycle
			free_mask = mispredict_free_list;
		end
		else
		begin
			if (free1_valid)
				free_mask[free1_idx] = 1'b1;
			if (free2_valid)
				free_mask[free2_idx] = 1'b1;	// both may name the same entry
		end
	end

	////////////////////
	// next state
	////////////////////

	// grants are applied after frees so an entry handed out this cycle stays taken,
	// and the zero register is masked off whatever the inputs say
	assign avail_next = (available | free_mask) & ~grant_mask & ~PRF_ZERO_MASK;

	always_ff @(posedge clock)
	begin
		if (!rst_n)
			available <= PRF_AVAIL_RESET;	// everything free except the zero register
		else
			available <= avail_next;
	end

	// full when the current pool is empty, independent of this cycle's frees
	assign prf_is_full = (available == '0);

endmodule

// File: logic/prf_free_pkg.sv
////////////////////
// per-entry bit vector types used for allocation and freeing
// one bit per physical register, bit i stands for entry i
////////////////////

package prf_free_pkg;

	`include "prf_params.svh"

	// availability, free, grant and ready masks all share this shape
	typedef logic [`PRF_SIZE-1:0] prf_vec_t;

	////////////////////
	// fixed masks
	////////////////////

	// only the zero register's bit is set here
	localparam prf_vec_t PRF_ZERO_MASK = prf_vec_t'(1) << `PRF_ZERO_IDX;

	// out of reset every entry is free apart from the zero register,
	// which never enters the free pool at all
	localparam prf_vec_t PRF_AVAIL_RESET = ~PRF_ZERO_MASK;

endpackage

// File: logic/prf_operand_read.sv
////////////////////
// one combinational source-operand read port
// returns the value when ready, otherwise the tag for the reservation station
////////////////////

`timescale 1ns/100ps

`include "prf_params.svh"

module prf_operand_read (
	input  prf_data_pkg::prf_tag_t   idx,	// entry named by the renamer
	input  prf_free_pkg::prf_vec_t   available,	// a free entry holds nothing valid
	input  prf_free_pkg::prf_vec_t   ready,
	input  prf_data_pkg::prf_value_t values [`PRF_SIZE],
	output prf_data_pkg::prf_value_t value,
	output logic                     valid	// 0 means value carries the tag instead
);

	import prf_data_pkg::*;

	always_comb
	begin
		if (idx == PRF_ZERO_TAG)
		begin
			// the zero register is a constant and is always usable
			value = '0;
			valid = 1'b1;
		end
		else if (ready[idx] && !available[idx])
		begin
			value = values[idx];	// allocated and written back
			valid = 1'b1;
		end
		else
		begin
			// pending operand, hand the tag on so the consumer can watch the CDB for it
			value = prf_value_t'(idx);
			valid = 1'b0;
		end
	end

endmodule

// File: logic/prf_params.svh
////////////////////
// sizing constants for the physical register file
// include this wherever a size or the zero register index is needed
////////////////////

`ifndef PRF_PARAMS_SVH
`define PRF_PARAMS_SVH

// number of physical registers held by the file
`define PRF_SIZE 64

// width of one register value in bits
`define PRF_DATA_W 64

// index of the reserved register that always reads as zero
`define PRF_ZERO_IDX 48

`endif

// File: logic/prf_top.sv
////////////////////
// physical register file for a single-thread out-of-order core
// allocation, two CDB write ports, four operand reads, retire and mispredict frees
////////////////////

`timescale 1ns/100ps

`include "prf_params.svh"

module prf_top (
	input  logic                     clock,
	input  logic                     rst_n,
	// allocation from the renamer
	input  logic                     alloc_req1,
	input  logic                     alloc_req2,
	output logic                     alloc_valid1,
	output logic                     alloc_valid2,
	output prf_data_pkg::prf_tag_t   alloc_idx1,
	output prf_data_pkg::prf_tag_t   alloc_idx2,
	output logic                     prf_is_full,
	// result writes
	input  logic                     cdb1_valid,
	input  prf_data_pkg::prf_tag_t   cdb1_tag,
	input  prf_data_pkg::prf_value_t cdb1_value,
	input  logic                     cdb2_valid,
	input  prf_data_pkg::prf_tag_t   cdb2_tag,
	input  prf_data_pkg::prf_value_t cdb2_value,
	// retirement and branch recovery
	input  logic                     free1_valid,
	input  prf_data_pkg::prf_tag_t   free1_idx,
	input  logic                     free2_valid,
	input  prf_data_pkg::prf_tag_t   free2_idx,
	input  logic                     mispredict_free_valid,
	input  prf_free_pkg::prf_vec_t   mispredict_free_list,
	// operand reads for two instructions
	input  prf_data_pkg::prf_tag_t   inst1_opa_idx,
	input  prf_data_pkg::prf_tag_t   inst1_opb_idx,
	input  prf_data_pkg::prf_tag_t   inst2_opa_idx,
	input  prf_data_pkg::prf_tag_t   inst2_opb_idx,
	output prf_data_pkg::prf_value_t inst1_opa_value,
	output prf_data_pkg::prf_value_t inst1_opb_value,
	output prf_data_pkg::prf_value_t inst2_opa_value,
	output prf_data_pkg::prf_value_t inst2_opb_value,
	output logic                     inst1_opa_valid,
	output logic                     inst1_opb_valid,
	output logic                     inst2_opa_valid,
	output logic                     inst2_opb_valid
);

	import prf_data_pkg::*;
	import prf_free_pkg::*;

	prf_vec_t   available;	// free pool as seen this cycle
	prf_vec_t   grant_mask;	// entries leaving the pool at the next edge
	prf_vec_t   ready;
	prf_value_t values [`PRF_SIZE];

	////////////////////
	// allocation and pool
	////////////////////

	prf_alloc_picker i_alloc_picker (.alloc_req1, .alloc_req2, .available, .grant_mask,
		.alloc_valid1, .alloc_valid2, .alloc_idx1, .alloc_idx2);

	prf_free_list i_free_list (.clock, .rst_n, .grant_mask, .free1_valid, .free2_valid,
		.free1_idx, .free2_idx, .mispredict_free_valid, .mispredict_free_list,
		.available, .prf_is_full);

	// storage side also watches the grants to drop stale ready bits
	prf_entry_array i_entry_array (.clock, .rst_n, .grant_mask, .cdb1_valid, .cdb1_tag,
		.cdb1_value, .cdb2_valid, .cdb2_tag, .cdb2_value, .ready, .values);

	////////////////////
	// read ports
	////////////////////

	prf_operand_read i_read_inst1_opa (.idx(inst1_opa_idx), .available, .ready, .values,
		.value(inst1_opa_value), .valid(inst1_opa_valid));
	prf_operand_read i_read_inst1_opb (.idx(inst1_opb_idx), .available, .ready, .values,
		.value(inst1_opb_value), .valid(inst1_opb_valid));
	prf_operand_read i_read_inst2_opa (.idx(inst2_opa_idx), .available, .ready, .values,
		.value(inst2_opa_value), .valid(inst2_opa_valid));
	prf_operand_read i_read_inst2_opb (.idx(inst2_opb_idx), .available, .ready, .values,
		.value(inst2_opb_value), .valid(inst2_opb_valid));

endmodule

// File: tests/prf_tb.sv
////////////////////
// self-checking testbench for the physical register file
// runs a per-cycle table of stimulus and expected outputs, then drains the free pool
////////////////////

`timescale 1ns/100ps

`include "prf_params.svh"

module prf_tb;

	import prf_data_pkg::*;
	import prf_free_pkg::*;

	localparam int NUM_ROWS       = 11;
	localparam int RESET_CYCLES   = 4;
	localparam int FILL_CYCLES    = 32;	// enough cycles to hand out every remaining entry
	localparam int TIMEOUT_CYCLES = 2*NUM_ROWS + FILL_CYCLES + RESET_CYCLES;

	logic       clock;
	logic       rst_n;
	logic       alloc_req1, alloc_req2, alloc_valid1, alloc_valid2, prf_is_full;
	prf_tag_t   alloc_idx1, alloc_idx2;
	logic       cdb1_valid, cdb2_valid;
	prf_tag_t   cdb1_tag, cdb2_tag;
	prf_value_t cdb1_value, cdb2_value;
	logic       free1_valid, free2_valid, mispredict_free_valid;
	prf_tag_t   free1_idx, free2_idx;
	prf_vec_t   mispredict_free_list;
	prf_tag_t   rd_idx [4];	// port order is inst1_opa, inst1_opb, inst2_opa, inst2_opb
	prf_value_t inst1_opa_value, inst1_opb_value, inst2_opa_value, inst2_opb_value;
	logic       inst1_opa_valid, inst1_opb_valid, inst2_opa_valid, inst2_opb_valid;

	////////////////////
	// stimulus table
	////////////////////

	string      row_name       [NUM_ROWS];
	logic       row_req1       [NUM_ROWS];
	logic       row_req2       [NUM_ROWS];
	logic       row_cdb1_valid [NUM_ROWS];
	prf_tag_t   row_cdb1_tag   [NUM_ROWS];
	prf_value_t row_cdb1_value [NUM_ROWS];
	logic       row_cdb2_valid [NUM_ROWS];
	prf_tag_t   row_cdb2_tag   [NUM_ROWS];
	prf_value_t row_cdb2_value [NUM_ROWS];
	logic       row_free1_valid[NUM_ROWS];
	prf_tag_t   row_free1_idx  [NUM_ROWS];
	logic       row_mp_valid   [NUM_ROWS];
	prf_vec_t   row_mp_list    [NUM_ROWS];
	prf_tag_t   row_rd_idx     [NUM_ROWS][4];
	logic       exp_valid1     [NUM_ROWS];
	prf_tag_t   exp_idx1       [NUM_ROWS];
	logic       exp_valid2     [NUM_ROWS];
	prf_tag_t   exp_idx2       [NUM_ROWS];
	logic       exp_full       [NUM_ROWS];
	logic       exp_rd_valid   [NUM_ROWS][4];
	prf_value_t exp_rd_value   [NUM_ROWS][4];

	logic [31:0] lfsr_state;
	prf_value_t  val_a, val_b, val_c, val_d;	// random CDB payloads
	int          checks;
	int          errors;
	int          cycle_count;

	prf_top i_prf_top (.clock, .rst_n, .alloc_req1, .alloc_req2, .alloc_valid1, .alloc_valid2,
		.alloc_idx1, .alloc_idx2, .prf_is_full, .cdb1_valid, .cdb1_tag, .cdb1_value,
		.cdb2_valid, .cdb2_tag, .cdb2_value, .free1_valid, .free1_idx, .free2_valid,
		.free2_idx, .mispredict_free_valid, .mispredict_free_list,
		.inst1_opa_idx(rd_idx[0]), .inst1_opb_idx(rd_idx[1]),
		.inst2_opa_idx(rd_idx[2]), .inst2_opb_idx(rd_idx[3]),
		.inst1_opa_value, .inst1_opb_value, .inst2_opa_value, .inst2_opb_value,
		.inst1_opa_valid, .inst1_opb_valid, .inst2_opa_valid, .inst2_opb_valid);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;	// 10 ns period
	end

	// taps 32, 22, 2, 1, the new bit shifts in at the bottom
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic draw_value(output prf_value_t v);
		v = '0;
		for (int b = 0; b < `PRF_DATA_W; b++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[`PRF_DATA_W-2:0], lfsr_state[0]};	// one step per bit taken
		end
	endtask

	// the free pool hands out tags in ascending order and never the zero register
	function automatic int next_pool_tag(input int tag);
		return (tag + 1 == `PRF_ZERO_IDX) ? tag + 2 : tag + 1;
	endfunction

	task automatic check_value(input string name, input logic [`PRF_DATA_W-1:0] expected,
		input logic [`PRF_DATA_W-1:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	////////////////////
	// table building
	////////////////////

	// idle row, every read port looks at the zero register which always reads 0
	task automatic clear_row(input int r, input string name);
		row_name[r] = name;
		row_req1[r] = 1'b0;
		row_req2[r] = 1'b0;
		row_cdb1_valid[r] = 1'b0;
		row_cdb1_tag[r] = '0;
		row_cdb1_value[r] = '0;
		row_cdb2_valid[r] = 1'b0;
		row_cdb2_tag[r] = '0;
		row_cdb2_value[r] = '0;
		row_free1_valid[r] = 1'b0;
		row_free1_idx[r] = '0;
		row_mp_valid[r] = 1'b0;
		row_mp_list[r] = '0;
		exp_valid1[r] = 1'b0;
		exp_idx1[r] = '0;
		exp_valid2[r] = 1'b0;
		exp_idx2[r] = '0;
		exp_full[r] = 1'b0;
		for (int p = 0; p < 4; p++)
		begin
			row_rd_idx[r][p] = prf_tag_t'(`PRF_ZERO_IDX);
			exp_rd_valid[r][p] = 1'b1;
			exp_rd_value[r][p] = '0;
		end
	endtask

	task automatic set_alloc(input int r, input logic q1, input logic q2, input logic v1,
		input int i1, input logic v2, input int i2);
		row_req1[r] = q1;
		row_req2[r] = q2;
		exp_valid1[r] = v1;
		exp_idx1[r] = prf_tag_t'(i1);
		exp_valid2[r] = v2;
		exp_idx2[r] = prf_tag_t'(i2);
	endtask

	task automatic set_read(input int r, input int p, input int idx, input logic v,
		input prf_value_t value);
		row_rd_idx[r][p] = prf_tag_t'(idx);
		exp_rd_valid[r][p] = v;
		exp_rd_value[r][p] = value;
	endtask

	task automatic build_table();
		clear_row(0, "reset_state");
		set_read(0, 0, 5, 1'b0, 5);	// a free entry reads back its own tag
		clear_row(1, "alloc_pair_low");
		set_alloc(1, 1'b1, 1'b1, 1'b1, 0, 1'b1, 1);
		clear_row(2, "alloc_pair_next");
		set_alloc(2, 1'b1, 1'b1, 1'b1, 2, 1'b1, 3);
		clear_row(3, "alloc_req2_only");
		set_alloc(3, 1'b0, 1'b1, 1'b0, 0, 1'b1, 4);
		row_cdb1_valid[3] = 1'b1;
		row_cdb1_tag[3] = 1;
		row_cdb1_value[3] = val_a;
		row_cdb2_valid[3] = 1'b1;
		row_cdb2_tag[3] = 0;
		row_cdb2_value[3] = val_d;
		set_read(3, 0, 1, 1'b0, 1);	// write lands at the coming edge, not yet visible
		set_read(3, 1, 0, 1'b0, 0);
		clear_row(4, "cdb_writes");
		row_cdb1_valid[4] = 1'b1;
		row_cdb1_tag[4] = 2;
		row_cdb1_value[4] = val_b;
		row_cdb2_valid[4] = 1'b1;
		row_cdb2_tag[4] = 2;
		row_cdb2_value[4] = val_c;
		set_read(4, 0, 1, 1'b1, val_a);
		set_read(4, 1, 0, 1'b1, val_d);
		set_read(4, 2, 2, 1'b0, 2);
		clear_row(5, "retire_free");
		row_free1_valid[5] = 1'b1;
		row_free1_idx[5] = 0;
		set_read(5, 0, 2, 1'b1, val_c);	// CDB 2 won the shared tag
		set_read(5, 1, 0, 1'b1, val_d);
		clear_row(6, "realloc_freed");
		set_alloc(6, 1'b1, 1'b0, 1'b1, 0, 1'b0, 0);
		set_read(6, 0, 0, 1'b0, 0);
		clear_row(7, "mispredict");
		row_mp_valid[7] = 1'b1;
		row_mp_list[7] = prf_vec_t'(4'b1110);	// entries 1 to 3
		row_free1_valid[7] = 1'b1;
		row_free1_idx[7] = 4;	// dropped since the mispredict replaces retire frees
		set_read(7, 0, 0, 1'b0, 0);
		set_read(7, 1, 1, 1'b1, val_a);
		set_read(7, 2, 3, 1'b0, 3);
		clear_row(8, "alloc_after_flush");
		set_alloc(8, 1'b1, 1'b1, 1'b1, 1, 1'b1, 2);
		set_read(8, 0, 1, 1'b0, 1);
		set_read(8, 1, 4, 1'b0, 4);
		clear_row(9, "alloc_third_freed");
		set_alloc(9, 1'b1, 1'b0, 1'b1, 3, 1'b0, 0);
		set_read(9, 0, 2, 1'b0, 2);
		clear_row(10, "retire_overridden");
		set_alloc(10, 1'b1, 1'b0, 1'b1, 5, 1'b0, 0);	// entry 4 was still held
	endtask

	////////////////////
	// apply and check
	////////////////////

	task apply_row(input int r);
		alloc_req1 <= row_req1[r];
		alloc_req2 <= row_req2[r];
		cdb1_valid <= row_cdb1_valid[r];
		cdb1_tag <= row_cdb1_tag[r];
		cdb1_value <= row_cdb1_value[r];
		cdb2_valid <= row_cdb2_valid[r];
		cdb2_tag <= row_cdb2_tag[r];
		cdb2_value <= row_cdb2_value[r];
		free1_valid <= row_free1_valid[r];
		free1_idx <= row_free1_idx[r];
		mispredict_free_valid <= row_mp_valid[r];
		mispredict_free_list <= row_mp_list[r];
		rd_idx[0] <= row_rd_idx[r][0];
		rd_idx[1] <= row_rd_idx[r][1];
		rd_idx[2] <= row_rd_idx[r][2];
		rd_idx[3] <= row_rd_idx[r][3];
	endtask

	task automatic check_row(input int r);
		prf_value_t act_value [4];
		logic       act_valid [4];
		act_value = '{inst1_opa_value, inst1_opb_value, inst2_opa_value, inst2_opb_value};
		act_valid = '{inst1_opa_valid, inst1_opb_valid, inst2_opa_valid, inst2_opb_valid};
		check_value({row_name[r], " alloc_valid1"}, exp_valid1[r], alloc_valid1);
		check_value({row_name[r], " alloc_idx1"}, exp_idx1[r], alloc_idx1);
		check_value({row_name[r], " alloc_valid2"}, exp_valid2[r], alloc_valid2);
		check_value({row_name[r], " alloc_idx2"}, exp_idx2[r], alloc_idx2);
		check_value({row_name[r], " prf_is_full"}, exp_full[r], prf_is_full);
		for (int p = 0; p < 4; p++)
		begin
			check_value($sformatf("%s read%0d valid", row_name[r], p), exp_rd_valid[r][p],
				act_valid[p]);
			check_value($sformatf("%s read%0d value", row_name[r], p), exp_rd_value[r][p],
				act_value[p]);
		end
	endtask

	// the table leaves entries 0 to 5 held, so the pool drains from 6 upward
	task automatic fill_pool();
		int   next_tag;
		int   cycles;
		int   exp_i1;
		int   exp_i2;
		logic exp_v2;
		next_tag = 6;
		cycles = 0;
		while (next_tag < `PRF_SIZE && cycles < FILL_CYCLES)
		begin
			@(posedge clock);
			alloc_req1 <= 1'b1;
			alloc_req2 <= 1'b1;
			@(negedge clock);
			exp_i1 = next_tag;
			next_tag = next_pool_tag(next_tag);
			exp_v2 = (next_tag < `PRF_SIZE);	// last cycle may only have one entry left
			exp_i2 = exp_v2 ? next_tag : 0;
			if (exp_v2)
				next_tag = next_pool_tag(next_tag);
			check_value("fill prf_is_full", 0, prf_is_full);
			check_value("fill alloc_valid1", 1, alloc_valid1);
			check_value("fill alloc_idx1", exp_i1, alloc_idx1);
			check_value("fill alloc_valid2", exp_v2, alloc_valid2);
			check_value("fill alloc_idx2", exp_i2, alloc_idx2);
			cycles++;
		end
	endtask

	task automatic check_exhausted();
		@(posedge clock);
		alloc_req1 <= 1'b1;
		alloc_req2 <= 1'b1;
		@(negedge clock);
		check_value("exhausted prf_is_full", 1, prf_is_full);
		check_value("exhausted alloc_valid1", 0, alloc_valid1);
		check_value("exhausted alloc_idx1", 0, alloc_idx1);
		check_value("exhausted alloc_valid2", 0, alloc_valid2);
		check_value("exhausted alloc_idx2", 0, alloc_idx2);
		@(posedge clock);
		alloc_req1 <= 1'b0;
		alloc_req2 <= 1'b0;
	endtask

	initial
	begin
		rst_n = 1'b0;
		alloc_req1 = 1'b0;
		alloc_req2 = 1'b0;
		cdb1_valid = 1'b0;
		cdb1_tag = '0;
		cdb1_value = '0;
		cdb2_valid = 1'b0;
		cdb2_tag = '0;
		cdb2_value = '0;
		free1_valid = 1'b0;
		free1_idx = '0;
		free2_valid = 1'b0;
		free2_idx = '0;
		mispredict_free_valid = 1'b0;
		mispredict_free_list = '0;
		rd_idx = '{default: '0};
		checks = 0;
		errors = 0;
		lfsr_state = 32'h9d82_49c3;
		draw_value(val_a);
		draw_value(val_b);
		draw_value(val_c);
		draw_value(val_d);
		build_table();
		repeat (RESET_CYCLES) @(posedge clock);
		rst_n <= 1'b1;
		for (int r = 0; r < NUM_ROWS; r++)
		begin
			@(posedge clock);
			apply_row(r);
			@(negedge clock);	// combinational outputs have settled by mid-cycle
			check_row(r);
		end
		fill_pool();
		check_exhausted();
		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// watchdog in case a wait never returns
	initial
	begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge clock);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
		$display("Regression failed");
		$finish;
	end

endmodule
